// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - include_dirs:
      - common
    files:
      - common/led_matrix_pkg.sv
      - rtl/uart_rx.sv
      - control/command_decoder.sv
      - rtl/framebuffer_ram.sv
      - scan/matrix_scan.sv
      - scan/framebuffer_fetch.sv
      - rtl/led_matrix_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_led_matrix.sv

// ==== common/led_matrix_macros.svh ====
/* panel geometry, modulation timing and command opcodes
   MATRIX_DIV must stay >= 3 so fetched pixel data settles before clk_pixel rises
   COLOR_DEPTH must be at least 2 */
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

`define MATRIX_COLS         16  // columns per row
`define MATRIX_SCAN_ROWS    8   // rows per half, 1/8 scan

// brightness bits per channel
`define COLOR_DEPTH         2

`define MATRIX_DIV          4   // clk_root cycles per scan tick
`define OE_BASE_TICKS       8   // display ticks of plane 0, doubled per plane

// 8N1 bit period in clk_root cycles
`define UART_TICKS_PER_BIT  16

`define CMD_PIXEL           8'h50  // address byte, then pixel byte
`define CMD_BRIGHTNESS      8'h42  // plane enable mask
`define CMD_COLOR           8'h43  // rgb enable mask

`endif

// ==== common/led_matrix_pkg.sv ====
/* shared vector types and FSM encodings of the HUB75 driver
   pixel layout is {blue, green, red}, COLOR_DEPTH bits each */
package led_matrix_pkg;

    `include "led_matrix_macros.svh"

    typedef logic [3*`COLOR_DEPTH-1:0] pixel_t;   // [1:0] red, [3:2] green, [5:4] blue
    typedef logic [3:0]                col_addr_t;
    typedef logic [2:0]                row_addr_t;
    typedef logic [6:0]                scan_addr_t; // {row, column}

    // {half, row, column}, half 0 is the top
    typedef logic [7:0]                fb_addr_t;

    typedef logic [`COLOR_DEPTH-1:0]   brightness_level_t;
    typedef logic [2:0]                rgb_t;       // [0] red, [1] green, [2] blue

    typedef enum logic [2:0] {
        cmd_idle,
        cmd_pixel_addr,
        cmd_pixel_data,
        cmd_bright_arg,
        cmd_color_arg
    } cmd_state_t;

    typedef enum logic [1:0] {
        scan_shift,
        scan_latch,
        scan_display
    } scan_state_t;

endpackage

// ==== compile.f ====
+incdir+common
common/led_matrix_pkg.sv
rtl/uart_rx.sv
control/command_decoder.sv
rtl/framebuffer_ram.sv
scan/matrix_scan.sv
scan/framebuffer_fetch.sv
rtl/led_matrix_top.sv
test/tb_led_matrix.sv

// ==== control/command_decoder.sv ====
/* byte-stream command parser; unknown opcodes are dropped
   no back-pressure, the next byte is always the pending command's operand */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module command_decoder (
    input  logic                              clk_root,
    input  logic                              rst_n,
    input  logic [7:0]                        rx_data,
    input  logic                              rx_valid,
    output led_matrix_pkg::fb_addr_t          write_address,
    output led_matrix_pkg::pixel_t            write_data,
    output logic                              write_enable,
    output led_matrix_pkg::rgb_t              rgb_enable,
    output led_matrix_pkg::brightness_level_t brightness_enable
);
    localparam int pixel_w = $bits(led_matrix_pkg::pixel_t);

    led_matrix_pkg::cmd_state_t state;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state             <= led_matrix_pkg::cmd_idle;
            write_enable      <= 1'b0;
            rgb_enable        <= '1;  // all channels shown
            brightness_enable <= '1;
        end else begin
            write_enable <= 1'b0;
            if (rx_valid) begin
                case (state)
                    led_matrix_pkg::cmd_idle: begin
                        case (rx_data)
                            `CMD_PIXEL:      state <= led_matrix_pkg::cmd_pixel_addr;
                            `CMD_BRIGHTNESS: state <= led_matrix_pkg::cmd_bright_arg;
                            `CMD_COLOR:      state <= led_matrix_pkg::cmd_color_arg;
                            default:         state <= led_matrix_pkg::cmd_idle;
                        endcase
                    end
                    led_matrix_pkg::cmd_pixel_addr: begin
                        state <= led_matrix_pkg::cmd_pixel_data;
                    end
                    led_matrix_pkg::cmd_pixel_data: begin
                        write_enable <= 1'b1;
                        state        <= led_matrix_pkg::cmd_idle;
                    end
                    led_matrix_pkg::cmd_bright_arg: begin
                        brightness_enable <= rx_data[`COLOR_DEPTH-1:0];
                        state             <= led_matrix_pkg::cmd_idle;
                    end
                    led_matrix_pkg::cmd_color_arg: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= led_matrix_pkg::cmd_idle;
                    end
                    default: state <= led_matrix_pkg::cmd_idle;
                endcase
            end
        end
    end

    // operands of a pixel write
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == led_matrix_pkg::cmd_pixel_addr) begin
            write_address <= rx_data;
        end
        if (rx_valid && state == led_matrix_pkg::cmd_pixel_data) begin
            write_data <= rx_data[pixel_w-1:0];  // top bits of the byte unused
        end
    end

    write_after_byte: assert property (
        @(posedge clk_root) disable iff (!rst_n) write_enable |-> $past(rx_valid)
    );

endmodule

// ==== rtl/framebuffer_ram.sv ====
/* one bank per panel half, written by fb_addr_t, read as a pair
   registered read, one cycle latency; contents undefined after power-up */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module framebuffer_ram (
    input  logic                       clk_root,
    input  led_matrix_pkg::fb_addr_t   write_address,
    input  led_matrix_pkg::pixel_t     write_data,
    input  logic                       write_enable,
    input  led_matrix_pkg::scan_addr_t read_address,
    output led_matrix_pkg::pixel_t     read_top,
    output led_matrix_pkg::pixel_t     read_bottom
);
    localparam int half_depth = `MATRIX_SCAN_ROWS * `MATRIX_COLS;

    led_matrix_pkg::pixel_t mem [2][half_depth];  // [0] top, [1] bottom

    always_ff @(posedge clk_root) begin
        if (write_enable) begin
            mem[write_address[7]][write_address[6:0]] <= write_data;  // msb picks the half
        end
        read_top    <= mem[0][read_address];
        read_bottom <= mem[1][read_address];
    end

endmodule

// ==== rtl/led_matrix_top.sv ====
/* HUB75 16x16 1/8-scan driver fed by an 8N1 command stream on serial_in
   output_enable_n is active low; all logic runs on clk_root */
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                      clk_root,
    input  logic                      rst_n,
    input  logic                      serial_in,
    output led_matrix_pkg::rgb_t      rgb_top,
    output led_matrix_pkg::rgb_t      rgb_bottom,
    output led_matrix_pkg::row_addr_t row_address,
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable_n
);
    logic [7:0]                        rx_data;
    logic                              rx_valid;
    led_matrix_pkg::fb_addr_t          write_address;
    led_matrix_pkg::pixel_t            write_data;
    logic                              write_enable;
    led_matrix_pkg::rgb_t              rgb_enable;
    led_matrix_pkg::brightness_level_t brightness_enable;

    // scan side
    led_matrix_pkg::col_addr_t         column_address;
    led_matrix_pkg::row_addr_t         shift_row;
    logic                              pixel_load_start;
    led_matrix_pkg::brightness_level_t brightness_mask;
    led_matrix_pkg::scan_addr_t        read_address;
    led_matrix_pkg::pixel_t            read_top;
    led_matrix_pkg::pixel_t            read_bottom;

    uart_rx u_uart_rx (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .serial_in(serial_in),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder u_command_decoder (
        .clk_root         (clk_root),
        .rst_n            (rst_n),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .write_address    (write_address),
        .write_data       (write_data),
        .write_enable     (write_enable),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_root     (clk_root),
        .write_address(write_address),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_address (read_address),
        .read_top     (read_top),
        .read_bottom  (read_bottom)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_root         (clk_root),
        .rst_n            (rst_n),
        .column_address   (column_address),
        .shift_row        (shift_row),
        .pixel_load_start (pixel_load_start),
        .brightness_mask  (brightness_mask),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .read_address     (read_address),
        .read_top         (read_top),
        .read_bottom      (read_bottom),
        .rgb_top          (rgb_top),
        .rgb_bottom       (rgb_bottom)
    );

    matrix_scan u_matrix_scan (
        .clk_root        (clk_root),
        .rst_n           (rst_n),
        .column_address  (column_address),
        .shift_row       (shift_row),
        .pixel_load_start(pixel_load_start),
        .brightness_mask (brightness_mask),
        .row_address     (row_address),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n)
    );

endmodule

// ==== rtl/uart_rx.sv ====
/* 8N1 receiver, LSB first, sampled at mid-bit
   a frame with a low stop bit is dropped; a new start needs a falling edge */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module uart_rx (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int tick_w = $clog2(`UART_TICKS_PER_BIT);

    logic [2:0]        sync_q;      // [1] synchronized line, [2] its previous value
    logic              busy;
    logic [3:0]        bit_cnt;     // 0 start, 1..8 data, 9 stop
    logic [tick_w-1:0] tick_cnt;
    logic              sample;

    assign sample = busy && (tick_cnt == '0);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            sync_q   <= '1;  // line idles high
            busy     <= 1'b0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[1:0], serial_in};
            rx_valid <= 1'b0;
            if (!busy) begin
                if (sync_q[2] && !sync_q[1]) begin
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    tick_cnt <= tick_w'(`UART_TICKS_PER_BIT / 2 - 1); // half a bit to mid start
                end
            end else if (sample) begin
                tick_cnt <= tick_w'(`UART_TICKS_PER_BIT - 1);
                bit_cnt  <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0 && sync_q[1]) begin
                    busy <= 1'b0;  // glitch, not a start bit
                end else if (bit_cnt == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= sync_q[1];  // framing error gives no strobe
                end
            end else begin
                tick_cnt <= tick_cnt - 1'b1;
            end
        end
    end

    // shift register doubles as the output byte
    always_ff @(posedge clk_root) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            rx_data <= {sync_q[1], rx_data[7:1]};
        end
    end

    rx_valid_single: assert property (
        @(posedge clk_root) disable iff (!rst_n) rx_valid |=> !rx_valid
    );

endmodule

// ==== scan/framebuffer_fetch.sv ====
/* reads the top/bottom pixel pair of one column and keeps the current plane bit
   rgb_top/rgb_bottom change 2 cycles after pixel_load_start, then hold */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module framebuffer_fetch (
    input  logic                              clk_root,
    input  logic                              rst_n,
    input  led_matrix_pkg::col_addr_t         column_address,
    input  led_matrix_pkg::row_addr_t         shift_row,
    input  logic                              pixel_load_start,
    input  led_matrix_pkg::brightness_level_t brightness_mask,
    input  led_matrix_pkg::rgb_t              rgb_enable,
    input  led_matrix_pkg::brightness_level_t brightness_enable,
    output led_matrix_pkg::scan_addr_t        read_address,
    input  led_matrix_pkg::pixel_t            read_top,
    input  led_matrix_pkg::pixel_t            read_bottom,
    output led_matrix_pkg::rgb_t              rgb_top,
    output led_matrix_pkg::rgb_t              rgb_bottom
);
    logic [1:0] load_pipe;  // [0] address issued, [1] ram data valid
    logic       plane_on;

    assign plane_on = |(brightness_enable & brightness_mask);

    // pick the masked plane bit of each channel
    function automatic led_matrix_pkg::rgb_t plane_bits(input led_matrix_pkg::pixel_t pix);
        led_matrix_pkg::rgb_t bits;
        for (int ch = 0; ch < 3; ch++) begin
            bits[ch] = |(pix[ch*`COLOR_DEPTH +: `COLOR_DEPTH] & brightness_mask);
        end
        return bits & rgb_enable & {3{plane_on}};
    endfunction

    always_ff @(posedge clk_root) begin
        if (pixel_load_start) begin
            read_address <= {shift_row, column_address};
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            load_pipe  <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_pipe <= {load_pipe[0], pixel_load_start};
            if (load_pipe[1]) begin
                rgb_top    <= plane_bits(read_top);
                rgb_bottom <= plane_bits(read_bottom);
            end
        end
    end

endmodule

// ==== scan/matrix_scan.sv ====
/* shift, latch, display per row and bit-plane, all stepped on a clk_root/MATRIX_DIV tick
   panel stays blanked while a row shifts in; plane b is shown OE_BASE_TICKS << b ticks */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module matrix_scan (
    input  logic                              clk_root,
    input  logic                              rst_n,
    output led_matrix_pkg::col_addr_t         column_address,
    output led_matrix_pkg::row_addr_t         shift_row,
    output logic                              pixel_load_start,
    output led_matrix_pkg::brightness_level_t brightness_mask,
    output led_matrix_pkg::row_addr_t         row_address,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              output_enable_n
);
    localparam int div_w = $clog2(`MATRIX_DIV);
    localparam int oe_w  = $clog2(`OE_BASE_TICKS << (`COLOR_DEPTH - 1));

    led_matrix_pkg::scan_state_t state;

    logic [div_w-1:0] div_cnt;
    logic             tick;
    logic             phase;       // 0 loads a column, 1 raises clk_pixel
    logic [1:0]       latch_step;
    logic [oe_w-1:0]  oe_cnt;
    logic             last_col;
    logic             last_row;

    assign tick     = (div_cnt == div_w'(`MATRIX_DIV - 1));
    assign last_col = (column_address == led_matrix_pkg::col_addr_t'(`MATRIX_COLS - 1));
    assign last_row = (shift_row == led_matrix_pkg::row_addr_t'(`MATRIX_SCAN_ROWS - 1));

    // fetch starts in the tick cycle, clk_pixel rises a full tick later
    assign pixel_load_start = tick && (state == led_matrix_pkg::scan_shift) && !phase;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state           <= led_matrix_pkg::scan_shift;
            phase           <= 1'b0;
            latch_step      <= '0;
            oe_cnt          <= '0;
            column_address  <= '0;
            shift_row       <= '0;
            brightness_mask <= led_matrix_pkg::brightness_level_t'(1);  // plane 0 first
            row_address     <= '0;
            clk_pixel       <= 1'b0;
            row_latch       <= 1'b0;
            output_enable_n <= 1'b1;
        end else if (tick) begin
            case (state)
                led_matrix_pkg::scan_shift: begin
                    phase <= !phase;
                    if (!phase) begin
                        clk_pixel <= 1'b0;
                    end else begin
                        clk_pixel      <= 1'b1;
                        column_address <= last_col ? '0 : column_address + 1'b1;
                        if (last_col) begin
                            state <= led_matrix_pkg::scan_latch;
                        end
                    end
                end
                led_matrix_pkg::scan_latch: begin
                    latch_step <= latch_step + 2'd1;
                    case (latch_step)
                        2'd0: begin
                            clk_pixel   <= 1'b0;
                            row_address <= shift_row;
                        end
                        2'd1: row_latch <= 1'b1;
                        default: begin
                            row_latch       <= 1'b0;
                            output_enable_n <= 1'b0;
                            latch_step      <= '0;
                            oe_cnt <= oe_w'(`OE_BASE_TICKS * brightness_mask - 1);  // mask is 2^b
                            state  <= led_matrix_pkg::scan_display;
                        end
                    endcase
                end
                default: begin
                    if (oe_cnt == '0) begin
                        output_enable_n <= 1'b1;
                        state           <= led_matrix_pkg::scan_shift;
                        brightness_mask <= {brightness_mask[`COLOR_DEPTH-2:0],
                                            brightness_mask[`COLOR_DEPTH-1]};
                        if (brightness_mask[`COLOR_DEPTH-1]) begin  // last plane of the row
                            shift_row <= last_row ? '0 : shift_row + 1'b1;
                        end
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    latch_blanked: assert property (
        @(posedge clk_root) disable iff (!rst_n) row_latch |-> output_enable_n
    );

endmodule

// ==== test/tb_led_matrix.sv ====
/* directed testbench for the HUB75 driver, commands go in as 8N1 frames on serial_in
   receive strobes are counted on the uart_rx instance inside the DUT
   framebuffer is undefined until written, so the first frame only checks scan order */
`timescale 1ns/1ps
`include "led_matrix_macros.svh"

module tb_led_matrix;
    localparam int latches       = `MATRIX_SCAN_ROWS * `COLOR_DEPTH;  // per frame
    localparam int frame_timeout = 16000;  // clk_root cycles, over four frames
    localparam int half_pixels   = `MATRIX_SCAN_ROWS * `MATRIX_COLS;

    logic                      clk_root;
    logic                      rst_n;
    logic                      serial_in;
    led_matrix_pkg::rgb_t      rgb_top;
    led_matrix_pkg::rgb_t      rgb_bottom;
    led_matrix_pkg::row_addr_t row_address;
    logic                      clk_pixel;
    logic                      row_latch;
    logic                      output_enable_n;

    int mismatch_count = 0;
    int failure_count  = 0;

    led_matrix_pkg::pixel_t            model [2 * half_pixels];  // indexed like fb_addr_t
    led_matrix_pkg::rgb_t              rgb_en_model    = '1;
    led_matrix_pkg::brightness_level_t bright_en_model = '1;

    // last captured frame, [row][plane][column]
    led_matrix_pkg::rgb_t      frame_top [`MATRIX_SCAN_ROWS][`COLOR_DEPTH][`MATRIX_COLS];
    led_matrix_pkg::rgb_t      frame_bot [`MATRIX_SCAN_ROWS][`COLOR_DEPTH][`MATRIX_COLS];
    led_matrix_pkg::row_addr_t latch_row [latches];
    int                        latch_plane [latches];
    int                        latch_rises [latches];
    int                        oe_violations;

    led_matrix_top UUT (
        .clk_root       (clk_root),
        .rst_n          (rst_n),
        .serial_in      (serial_in),
        .rgb_top        (rgb_top),
        .rgb_bottom     (rgb_bottom),
        .row_address    (row_address),
        .clk_pixel      (clk_pixel),
        .row_latch      (row_latch),
        .output_enable_n(output_enable_n)
    );

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root;
    end

    task automatic finish_run();
        $display("%0d value mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        failure_count++;
        $display("error: at %0t gave up waiting for %s", $time, what);
    endtask

    task automatic check_rgb(input string name, input led_matrix_pkg::rgb_t expected,
                             input led_matrix_pkg::rgb_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("error: %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_row(input string name, input led_matrix_pkg::row_addr_t expected,
                             input led_matrix_pkg::row_addr_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("error: %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            mismatch_count++;
            $display("error: %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("error: %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    // level bit of this plane per channel, gated by both enables
    function automatic led_matrix_pkg::rgb_t expected_rgb(input led_matrix_pkg::pixel_t pix,
                                                          input int plane);
        led_matrix_pkg::rgb_t result;
        for (int ch = 0; ch < 3; ch++) begin
            result[ch] = pix[ch * `COLOR_DEPTH + plane] && rgb_en_model[ch]
                         && bright_en_model[plane];
        end
        return result;
    endfunction

    // start, 8 data bits LSB first, stop, one idle bit
    task automatic send_byte(input logic [7:0] data, input logic stop_level);
        logic [10:0] frame;
        int          strobes;
        frame   = {1'b1, stop_level, data, 1'b0};
        strobes = 0;
        for (int i = 0; i < 11; i++) begin
            @(posedge clk_root);
            serial_in <= frame[i];
            for (int t = 0; t < `UART_TICKS_PER_BIT; t++) begin
                @(negedge clk_root);
                if (UUT.u_uart_rx.rx_valid === 1'b1) strobes++;
                if (t < `UART_TICKS_PER_BIT - 1) @(posedge clk_root);
            end
        end
        check_count($sformatf("rx_valid strobes for byte %02h", data), stop_level ? 1 : 0,
                    strobes);
    endtask

    task automatic send_command(input logic [7:0] opcode, input logic [7:0] operand);
        send_byte(opcode, 1'b1);
        send_byte(operand, 1'b1);
    endtask

    task automatic write_pixel(input led_matrix_pkg::fb_addr_t addr,
                               input led_matrix_pkg::pixel_t pix);
        send_byte(`CMD_PIXEL, 1'b1);
        send_byte(addr, 1'b1);
        send_byte(8'(pix), 1'b1);
        model[addr] = pix;
    endtask

    // one frame from row 0 plane 0, found as the first latch after a row 7 latch
    task automatic capture_frame();
        logic                      prev_clk;
        logic                      prev_latch;
        logic                      synced;
        logic                      prev_row_ok;
        led_matrix_pkg::row_addr_t prev_row;
        led_matrix_pkg::rgb_t      shift_top [`MATRIX_COLS];
        led_matrix_pkg::rgb_t      shift_bot [`MATRIX_COLS];
        int                        rises;
        int                        n_latch;
        int                        plane;
        int                        cycles;
        prev_clk      = clk_pixel;
        prev_latch    = row_latch;
        synced        = 1'b0;
        prev_row_ok   = 1'b0;
        prev_row      = '0;
        rises         = 0;
        n_latch       = 0;
        plane         = 0;
        cycles        = 0;
        oe_violations = 0;
        while (n_latch < latches && cycles < frame_timeout) begin
            @(negedge clk_root);
            cycles++;
            if (clk_pixel && !prev_clk) begin
                if (rises < `MATRIX_COLS) begin
                    shift_top[rises] = rgb_top;
                    shift_bot[rises] = rgb_bottom;
                end
                rises++;
            end
            if (synced && row_latch && output_enable_n !== 1'b1) oe_violations++;
            if (row_latch && !prev_latch) begin
                if (!synced && prev_row_ok && prev_row == 3'd7 && row_address == 3'd0) begin
                    synced = 1'b1;
                    plane  = 0;
                end else if (synced) begin
                    plane = (row_address == prev_row) ? plane + 1 : 0;
                end
                if (synced) begin
                    latch_row[n_latch]   = row_address;
                    latch_plane[n_latch] = plane;
                    latch_rises[n_latch] = rises;
                    if (plane < `COLOR_DEPTH) begin
                        for (int c = 0; c < `MATRIX_COLS; c++) begin
                            frame_top[row_address][plane][c] = shift_top[c];
                            frame_bot[row_address][plane][c] = shift_bot[c];
                        end
                    end
                    n_latch++;
                end
                prev_row    = row_address;
                prev_row_ok = 1'b1;
                rises       = 0;
            end
            prev_clk   = clk_pixel;
            prev_latch = row_latch;
        end
        if (n_latch < latches) report_timeout("a full panel frame");
    endtask

    task automatic check_scan_order();
        for (int k = 0; k < latches; k++) begin
            check_row($sformatf("row_address at latch %0d", k),
                      led_matrix_pkg::row_addr_t'(k / `COLOR_DEPTH), latch_row[k]);
            check_count($sformatf("plane of latch %0d", k), k % `COLOR_DEPTH, latch_plane[k]);
            check_count($sformatf("clk_pixel rises before latch %0d", k), `MATRIX_COLS,
                        latch_rises[k]);
        end
        check_count("row_latch cycles with output_enable_n low", 0, oe_violations);
    endtask

    task automatic compare_frame(input led_matrix_pkg::rgb_t dark_channels,
                                 input led_matrix_pkg::brightness_level_t dark_planes);
        int    lit;
        int    idx;
        string where;
        lit = 0;
        for (int r = 0; r < `MATRIX_SCAN_ROWS; r++) begin
            for (int b = 0; b < `COLOR_DEPTH; b++) begin
                for (int c = 0; c < `MATRIX_COLS; c++) begin
                    idx   = r * `MATRIX_COLS + c;
                    where = $sformatf("row %0d plane %0d column %0d", r, b, c);
                    check_rgb({"rgb_top ", where}, expected_rgb(model[idx], b),
                              frame_top[r][b][c]);
                    check_rgb({"rgb_bottom ", where}, expected_rgb(model[half_pixels + idx], b),
                              frame_bot[r][b][c]);
                    lit += $countones((frame_top[r][b][c] | frame_bot[r][b][c])
                                      & (dark_planes[b] ? 3'b111 : dark_channels));
                end
            end
        end
        if (dark_channels != '0 || dark_planes != '0) begin
            check_count("lit outputs in disabled channels or planes", 0, lit);
        end
    endtask

    task automatic idle_outputs(input string when_txt);
        check_level({"clk_pixel ", when_txt}, 1'b0, clk_pixel);
        check_level({"row_latch ", when_txt}, 1'b0, row_latch);
        check_level({"output_enable_n ", when_txt}, 1'b1, output_enable_n);
        check_rgb({"rgb_top ", when_txt}, '0, rgb_top);
        check_rgb({"rgb_bottom ", when_txt}, '0, rgb_bottom);
    endtask

    task automatic reset_outputs_idle();
        repeat (3) begin
            @(negedge clk_root);
            idle_outputs("during reset");
        end
        @(posedge clk_root);  // fourth edge in reset
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk_root);
            idle_outputs("after reset");
        end
    endtask

    task automatic random_pixels_shown();
        for (int a = 0; a < 2 * half_pixels; a++) begin
            write_pixel(led_matrix_pkg::fb_addr_t'(a), led_matrix_pkg::pixel_t'($urandom));
        end
        capture_frame();
        compare_frame('0, '0);
    endtask

    task automatic green_only_shown();
        send_command(`CMD_COLOR, 8'h02);
        rgb_en_model = 3'b010;
        capture_frame();
        compare_frame(3'b101, '0);  // red and blue dark
    endtask

    task automatic plane_zero_blanked();
        send_command(`CMD_COLOR, 8'h07);
        rgb_en_model = 3'b111;
        send_command(`CMD_BRIGHTNESS, 8'h02);
        bright_en_model = 2'b10;
        capture_frame();
        compare_frame('0, 2'b01);
    endtask

    // unknown opcode, then a pixel byte lost to a framing error
    task automatic bad_bytes_ignored();
        led_matrix_pkg::fb_addr_t addr;
        led_matrix_pkg::pixel_t   good_pix;
        led_matrix_pkg::pixel_t   bad_pix;
        addr     = led_matrix_pkg::fb_addr_t'($urandom);
        good_pix = model[addr] ^ 6'h15;
        bad_pix  = model[addr] ^ 6'h2a;
        send_byte(8'ha5, 1'b1);
        send_byte(`CMD_PIXEL, 1'b1);
        send_byte(addr, 1'b1);
        send_byte(8'(bad_pix), 1'b0);
        send_byte(8'(good_pix), 1'b1);
        model[addr] = good_pix;
        send_command(`CMD_BRIGHTNESS, 8'h03);  // both planes back on
        bright_en_model = 2'b11;
        capture_frame();
        compare_frame('0, '0);
    endtask

    initial begin
        int seed;
        rst_n     = 1'b0;
        serial_in = 1'b1;  // line idle
        seed      = $urandom(87761);
        reset_outputs_idle();
        capture_frame();
        check_scan_order();
        random_pixels_shown();
        green_only_shown();
        plane_zero_blanked();
        bad_bytes_ignored();
        finish_run();
    end

endmodule
